//--- rtl/alu_pkg.sv
`default_nettype none

package alu_pkg;

        parameter int operand_width = 32;

        // Encoding is shared with the trace file of the testbench
        typedef enum logic [4:0] {
                op_sll   = 5'd0,
                op_srl   = 5'd1,
                op_sra   = 5'd2,
                op_add   = 5'd3,
                op_sub   = 5'd4,
                op_lui   = 5'd5,
                op_auipc = 5'd6,
                op_xor   = 5'd7,
                op_or    = 5'd8,
                op_and   = 5'd9,
                op_slt   = 5'd10,
                op_sltu  = 5'd11,
                op_div   = 5'd12,
                op_divu  = 5'd13,
                op_rem   = 5'd14,
                op_remu  = 5'd15
        } alu_op_t;

        typedef struct packed {
                alu_op_t                  op;
                logic [operand_width-1:0] a;
                logic [operand_width-1:0] b;
        } alu_issue_t;

        typedef struct packed {
                logic [operand_width-1:0] value;
                logic                     zero;  // Set when value is 0
        } alu_result_t;

endpackage

`default_nettype wire

//--- rtl/div_int.sv
`timescale 1ns/1ns
`default_nettype none

module div_int
(
        input  logic                              clk,
        input  logic                              arst_n,
        input  logic                              start,
        input  logic [alu_pkg::operand_width-1:0] a,
        input  logic [alu_pkg::operand_width-1:0] b,
        input  logic                              is_signed,
        output logic                              busy,
        output logic                              done,
        output logic [alu_pkg::operand_width-1:0] quot,
        output logic [alu_pkg::operand_width-1:0] rem
);

        localparam int w = alu_pkg::operand_width;

        logic [$clog2(w)-1:0] count;
        logic [w-1:0] divisor;
        logic [w-1:0] q_reg;  // Dividend bits leave at the top as quotient bits enter below
        logic [w-1:0] r_reg;
        logic q_neg;
        logic r_neg;
        logic dbz;
        logic a_neg;
        logic b_neg;
        logic [w:0] r_shift;
        logic [w:0] r_diff;
        logic fits;

        assign a_neg   = is_signed & a[w-1];
        assign b_neg   = is_signed & b[w-1];
        assign r_shift = {r_reg, q_reg[w-1]};
        assign r_diff  = r_shift - {1'b0, divisor};
        assign fits    = r_shift >= {1'b0, divisor};

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        busy  <= 1'b0;
                        done  <= 1'b0;
                        count <= '0;
                end
                else
                begin
                        done <= 1'b0;
                        if (start)
                        begin
                                busy  <= 1'b1;
                                count <= '0;
                        end
                        else if (busy)
                        begin
                                count <= count + 1'b1;
                                if (&count)  // Last of the w steps
                                begin
                                        busy <= 1'b0;
                                        done <= 1'b1;
                                end
                        end
                end
        end

        // Setup cycle takes magnitudes, then one restoring step per cycle
        always_ff @(posedge clk)
        begin
                if (start)
                begin
                        divisor <= b_neg ? -b : b;
                        q_reg   <= a_neg ? -a : a;
                        r_reg   <= '0;
                        q_neg   <= a_neg ^ b_neg;
                        r_neg   <= a_neg;
                        dbz     <= b == '0;
                end
                else if (busy)
                begin
                        q_reg <= {q_reg[w-2:0], fits};
                        r_reg <= fits ? r_diff[w-1:0] : r_shift[w-1:0];
                end
        end

        // Remainder keeps the sign of the dividend
        assign quot = dbz ? '1 : (q_neg ? -q_reg : q_reg);
        assign rem  = r_neg ? -r_reg : r_reg;

        a_start_idle : assert property (@(posedge clk) disable iff (!arst_n) start |-> !busy)
                else $error("divider started while busy");

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu
(
        input  logic                 clk,
        input  logic                 arst_n,
        input  logic                 start,
        input  alu_pkg::alu_issue_t  issue,
        input  logic                 drain,
        output logic                 idle,
        output logic                 done,
        output alu_pkg::alu_result_t result
);

        localparam int w = alu_pkg::operand_width;

        logic [4:0] shamt;
        logic [w-1:0] upper_imm;
        logic [w-1:0] single_value;
        logic [w-1:0] div_quot;
        logic [w-1:0] div_rem;
        logic [w-1:0] div_value;
        logic is_div;
        logic div_signed;
        logic div_start;
        logic div_busy;
        logic div_done;
        logic rem_sel;

        assign shamt      = issue.b[4:0];
        assign upper_imm  = {issue.b[19:0], 12'h000};
        assign is_div     = issue.op inside {alu_pkg::op_div, alu_pkg::op_divu,
                                             alu_pkg::op_rem, alu_pkg::op_remu};
        assign div_signed = issue.op inside {alu_pkg::op_div, alu_pkg::op_rem};
        assign div_start  = start & is_div;
        assign div_value  = rem_sel ? div_rem : div_quot;

        always_comb
        begin
                case (issue.op)
                        alu_pkg::op_sll:   single_value = issue.a << shamt;
                        alu_pkg::op_srl:   single_value = issue.a >> shamt;
                        alu_pkg::op_sra:   single_value = $signed(issue.a) >>> shamt;
                        alu_pkg::op_add:   single_value = issue.a + issue.b;
                        alu_pkg::op_sub:   single_value = issue.a - issue.b;
                        alu_pkg::op_lui:   single_value = upper_imm;
                        alu_pkg::op_auipc: single_value = issue.a + upper_imm;
                        alu_pkg::op_xor:   single_value = issue.a ^ issue.b;
                        alu_pkg::op_or:    single_value = issue.a | issue.b;
                        alu_pkg::op_and:   single_value = issue.a & issue.b;
                        alu_pkg::op_slt:   single_value = w'($signed(issue.a) < $signed(issue.b));
                        alu_pkg::op_sltu:  single_value = w'(issue.a < issue.b);
                        default:           single_value = '0;
                endcase
        end

        // Lane is busy from start until the merger drains it
        assign idle = !(done | div_busy | div_done);

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        done <= 1'b0;
                else if (drain)
                        done <= 1'b0;
                else if ((start && !is_div) || div_done)
                        done <= 1'b1;
        end

        always_ff @(posedge clk)
        begin
                if (start)
                        rem_sel <= issue.op inside {alu_pkg::op_rem, alu_pkg::op_remu};
                if (start && !is_div)
                begin
                        result.value <= single_value;
                        result.zero  <= single_value == '0;
                end
                else if (div_done)
                begin
                        result.value <= div_value;
                        result.zero  <= div_value == '0;
                end
        end

        div_int u_div
        (
                .clk       (clk),
                .arst_n    (arst_n),
                .start     (div_start),
                .a         (issue.a),
                .b         (issue.b),
                .is_signed (div_signed),
                .busy      (div_busy),
                .done      (div_done),
                .quot      (div_quot),
                .rem       (div_rem)
        );

        a_drain_done : assert property (@(posedge clk) disable iff (!arst_n) drain |-> done)
                else $error("lane drained without a finished result");

endmodule

`default_nettype wire

//--- rtl/issue_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module issue_dispatch
#(
        parameter int NUM_LANES = 4
)
(
        input  logic                 clk,
        input  logic                 arst_n,
        input  alu_pkg::alu_issue_t  issue,
        input  logic                 issue_valid,
        output logic                 ready,
        input  logic [NUM_LANES-1:0] lane_idle,
        output logic [NUM_LANES-1:0] lane_start,
        output alu_pkg::alu_issue_t  lane_issue
);

        localparam int ptr_w = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

        logic [ptr_w-1:0] ptr;
        logic accept;

        // Only the lane next in turn may take an operation
        assign ready  = lane_idle[ptr];
        assign accept = issue_valid & ready;

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        ptr        <= '0;
                        lane_start <= '0;
                end
                else
                begin
                        lane_start <= '0;
                        if (accept)
                        begin
                                lane_start[ptr] <= 1'b1;
                                ptr <= (ptr == ptr_w'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
                        end
                end
        end

        always_ff @(posedge clk)
        begin
                if (accept)
                        lane_issue <= issue;  // Shared by all lanes, read in the start cycle
        end

        a_issue_ready : assert property (@(posedge clk) disable iff (!arst_n)
                                         issue_valid |-> ready)
                else $error("issue_valid while ready is low");

endmodule

`default_nettype wire

//--- rtl/result_merge.sv
`timescale 1ns/1ns
`default_nettype none

module result_merge
#(
        parameter int NUM_LANES = 4
)
(
        input  logic                                  clk,
        input  logic                                  arst_n,
        input  logic [NUM_LANES-1:0]                  lane_done,
        input  alu_pkg::alu_result_t [NUM_LANES-1:0]  lane_result,
        output logic [NUM_LANES-1:0]                  lane_drain,
        output alu_pkg::alu_result_t                  result,
        output logic                                  result_valid
);

        localparam int ptr_w = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

        logic [ptr_w-1:0] ptr;
        logic take;

        // Following the same turn order as the dispatcher keeps issue order
        assign take = lane_done[ptr];

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        ptr          <= '0;
                        lane_drain   <= '0;
                        result_valid <= 1'b0;
                end
                else
                begin
                        lane_drain   <= '0;
                        result_valid <= take;
                        if (take)
                        begin
                                lane_drain[ptr] <= 1'b1;
                                ptr <= (ptr == ptr_w'(NUM_LANES - 1)) ? '0 : ptr + 1'b1;
                        end
                end
        end

        always_ff @(posedge clk)
        begin
                if (take)
                        result <= lane_result[ptr];
        end

endmodule

`default_nettype wire

//--- rtl/alu_cluster.sv
`timescale 1ns/1ns
`default_nettype none

module alu_cluster
#(
        parameter int NUM_LANES = 4
)
(
        input  logic                 clk,
        input  logic                 arst_n,
        input  alu_pkg::alu_issue_t  issue,
        input  logic                 issue_valid,
        output logic                 ready,
        output alu_pkg::alu_result_t result,
        output logic                 result_valid
);

        logic [NUM_LANES-1:0] lane_idle;
        logic [NUM_LANES-1:0] lane_start;
        logic [NUM_LANES-1:0] lane_done;
        logic [NUM_LANES-1:0] lane_drain;
        alu_pkg::alu_issue_t lane_issue;
        alu_pkg::alu_result_t [NUM_LANES-1:0] lane_result;

        issue_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch
        (
                .clk         (clk),
                .arst_n      (arst_n),
                .issue       (issue),
                .issue_valid (issue_valid),
                .ready       (ready),
                .lane_idle   (lane_idle),
                .lane_start  (lane_start),
                .lane_issue  (lane_issue)
        );

        for (genvar i = 0; i < NUM_LANES; i++)
        begin : g_lane
                alu u_alu
                (
                        .clk    (clk),
                        .arst_n (arst_n),
                        .start  (lane_start[i]),
                        .issue  (lane_issue),
                        .drain  (lane_drain[i]),
                        .idle   (lane_idle[i]),
                        .done   (lane_done[i]),
                        .result (lane_result[i])
                );
        end

        result_merge #(.NUM_LANES(NUM_LANES)) u_merge
        (
                .clk          (clk),
                .arst_n       (arst_n),
                .lane_done    (lane_done),
                .lane_result  (lane_result),
                .lane_drain   (lane_drain),
                .result       (result),
                .result_valid (result_valid)
        );

endmodule

`default_nettype wire

//--- test/result_checker.sv
`timescale 1ns/1ns
`default_nettype none

module result_checker
(
        input  logic                 clk,
        input  logic                 arst_n,
        input  logic                 expected_valid,
        input  alu_pkg::alu_result_t expected,
        input  logic                 result_valid,
        input  alu_pkg::alu_result_t result,
        output int                   pass_count,
        output int                   fail_count,
        output int                   result_count,
        output int                   pending
);

        alu_pkg::alu_result_t expected_q[$];

        task automatic check_result();
                alu_pkg::alu_result_t want;
                result_count++;
                if (expected_q.size() == 0)
                begin
                        fail_count++;
                        $display("test %0d failed, no operation was outstanding", result_count);
                end
                else
                begin
                        want = expected_q.pop_front();  // Oldest accepted issue
                        if (result.value !== want.value)
                        begin
                                fail_count++;
                                $display("** Error result.value: expected %h got %h (test %0d)",
                                         want.value, result.value, result_count);
                        end
                        else if (result.zero !== want.zero)
                        begin
                                fail_count++;
                                $display("** Error result.zero: expected %h got %h (test %0d)",
                                         want.zero, result.zero, result_count);
                        end
                        else
                        begin
                                pass_count++;
                                $display("test %0d passed", result_count);
                        end
                end
        endtask

        // Sampled mid-cycle where the DUT outputs and the driven expectations have settled
        always @(negedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        expected_q.delete();
                        pass_count = 0;
                        fail_count = 0;
                        result_count = 0;
                        pending = 0;
                end
                else
                begin
                        if (expected_valid)
                                expected_q.push_back(expected);
                        if (result_valid)
                                check_result();
                        pending = expected_q.size();
                end
        end

endmodule

`default_nettype wire

//--- test/alu_cluster_tb.sv
`timescale 1ns/1ns
`default_nettype none

module alu_cluster_tb;

        localparam int max_ops = 64;
        localparam int w = alu_pkg::operand_width;

        logic clk;
        logic arst_n;
        alu_pkg::alu_issue_t issue;
        logic issue_valid;
        logic ready;
        alu_pkg::alu_result_t result;
        logic result_valid;
        alu_pkg::alu_result_t expected;
        logic expected_valid;
        int pass_count;
        int fail_count;
        int result_count;
        int pending;

        logic [4:0] trace_op [max_ops];
        logic [w-1:0] trace_a [max_ops];
        logic [w-1:0] trace_b [max_ops];
        logic [w-1:0] trace_value [max_ops];
        logic trace_zero [max_ops];
        int n_ops;
        int seed;
        int stall_cycles;
        int misc_fails;
        bit loaded;

        alu_cluster #(.NUM_LANES(4)) uut
        (
                .clk          (clk),
                .arst_n       (arst_n),
                .issue        (issue),
                .issue_valid  (issue_valid),
                .ready        (ready),
                .result       (result),
                .result_valid (result_valid)
        );

        result_checker u_checker
        (
                .clk            (clk),
                .arst_n         (arst_n),
                .expected_valid (expected_valid),
                .expected       (expected),
                .result_valid   (result_valid),
                .result         (result),
                .pass_count     (pass_count),
                .fail_count     (fail_count),
                .result_count   (result_count),
                .pending        (pending)
        );

        always #2 clk = ~clk;

        task automatic load_trace(input int fd);
                int cnt;
                string line;
                logic [w-1:0] f_op;
                logic [w-1:0] f_a;
                logic [w-1:0] f_b;
                logic [w-1:0] f_value;
                logic [w-1:0] f_zero;
                n_ops = 0;
                while (!$feof(fd) && n_ops < max_ops)
                begin
                        cnt = $fgets(line, fd);
                        if (cnt > 0 && line[0] != "#")
                        begin
                                cnt = $sscanf(line, "%h %h %h %h %h",
                                              f_op, f_a, f_b, f_value, f_zero);
                                if (cnt == 5)
                                begin
                                        trace_op[n_ops] = f_op[4:0];
                                        trace_a[n_ops] = f_a;
                                        trace_b[n_ops] = f_b;
                                        trace_value[n_ops] = f_value;
                                        trace_zero[n_ops] = f_zero[0];
                                        n_ops++;
                                end
                        end
                end
                $fclose(fd);
        endtask

        // Entered and left 1 ns after a rising edge
        task automatic issue_entry(input int idx);
                int gap;
                gap = $unsigned($random(seed)) % 4;
                repeat (gap)
                begin
                        @(posedge clk);
                        #1;
                end
                while (!ready)
                begin
                        stall_cycles++;
                        @(posedge clk);
                        #1;
                end
                issue.op = alu_pkg::alu_op_t'(trace_op[idx]);
                issue.a = trace_a[idx];
                issue.b = trace_b[idx];
                issue_valid = 1'b1;
                expected.value = trace_value[idx];
                expected.zero = trace_zero[idx];
                expected_valid = 1'b1;  // Ready was high, so this edge accepts the issue
                @(posedge clk);
                #1;
                issue_valid = 1'b0;
                expected_valid = 1'b0;
        endtask

        initial
        begin
                wait (loaded);
                #(n_ops * 40 * 4 + 200);
                $display("timeout, only %0d of %0d results arrived", result_count, n_ops);
                $display("SOME TESTS FAILED");
                $finish;
        end

        initial
        begin
                int fd;
                clk = 1'b0;
                arst_n = 1'b0;
                issue = '0;
                issue_valid = 1'b0;
                expected = '0;
                expected_valid = 1'b0;
                seed = 32'h3d00c2e9;
                stall_cycles = 0;
                misc_fails = 0;
                fd = $fopen("test/alu_trace.txt", "r");
                if (fd == 0)
                begin
                        $display("cannot open the trace file test/alu_trace.txt");
                        $display("SOME TESTS FAILED");
                        $finish;
                end
                else
                begin
                        load_trace(fd);
                        loaded = 1'b1;
                        repeat (3) @(posedge clk);
                        #1 arst_n = 1'b1;
                        for (int i = 0; i < n_ops; i++)
                                issue_entry(i);
                        wait (pending == 0);
                        repeat (10) @(posedge clk);  // Room for any stray result pulse
                        if (stall_cycles == 0)
                        begin
                                misc_fails++;
                                $display("ready never dropped during the back-to-back divisions");
                        end
                        if (result_count != n_ops)
                        begin
                                misc_fails++;
                                $display("%0d result pulses came for %0d accepted issues",
                                         result_count, n_ops);
                        end
                        $display("%0d tests passed, %0d failed, %0d stall cycles", pass_count,
                                 fail_count + misc_fails, stall_cycles);
                        if (fail_count + misc_fails == 0 && pass_count == n_ops)
                                $display("ALL TESTS PASSED");
                        else
                                $display("SOME TESTS FAILED");
                        $finish;
                end
        end

endmodule

`default_nettype wire

//--- test/alu_trace.txt
# op a b expected_value expected_zero, all hex, one operation per line
# op codes: 0 sll 1 srl 2 sra 3 add 4 sub 5 lui 6 auipc 7 xor 8 or 9 and a slt b sltu c div d divu e rem f remu
03 7fffffff 00000001 80000000 0
03 ffffffff 00000001 00000000 1
04 00000000 00000001 ffffffff 0
00 00000001 00000024 00000010 0
02 80000000 00000004 f8000000 0
01 80000000 0000001f 00000001 0
05 12345678 000abcde abcde000 0
06 00001000 fff00001 00002000 0
07 ffff0000 0f0f0f0f f0f00f0f 0
09 f0f0f0f0 0f0f0f0f 00000000 1
0a ffffffff 00000001 00000001 0
0b ffffffff 00000001 00000000 1
0c fffffff9 00000002 fffffffd 0
0e fffffff9 00000002 ffffffff 0
0c 00000007 fffffffe fffffffd 0
0e 00000007 fffffffe 00000001 0
0d fffffff9 00000002 7ffffffc 0
0f fffffff9 00000002 00000001 0
0c 00000064 00000000 ffffffff 0
0e 00000064 00000000 00000064 0
0d 12345678 00000000 ffffffff 0
0c 80000000 ffffffff 80000000 0
0e 80000000 ffffffff 00000000 1
0d 00000064 00000007 0000000e 0
03 00000001 00000002 00000003 0
07 0000aaaa 0000aaaa 00000000 1
0c 000003e8 00000003 0000014d 0
0e 000003e8 00000003 00000001 0
0d 0000ffff 00000010 00000fff 0
0f 0000ffff 00000010 0000000f 0
0c ffffff9c 00000007 fffffff2 0
0e ffffff9c 00000007 fffffffe 0

//--- alu_cluster.f
rtl/alu_pkg.sv
rtl/div_int.sv
rtl/alu.sv
rtl/issue_dispatch.sv
rtl/result_merge.sv
rtl/alu_cluster.sv
test/result_checker.sv
test/alu_cluster_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f alu_cluster.f --top-module alu_cluster_tb -o alu_cluster_sim &&
./obj_dir/alu_cluster_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
